// File: Bender.yml
package:
  name: frame_buffer

sources:
  - verilog/video_pkg.sv
  - verilog/raster_timing.sv
  - verilog/bus_memory.sv
  - verilog/line_fetch.sv
  - verilog/pixel_shifter.sv
  - verilog/frame_buffer_top.sv
  - target: test
    files:
      - testbench/frame_buffer_props.sv
      - testbench/tb_frame_buffer.sv

// File: sources.f
verilog/video_pkg.sv
verilog/raster_timing.sv
verilog/bus_memory.sv
verilog/line_fetch.sv
verilog/pixel_shifter.sv
verilog/frame_buffer_top.sv
testbench/frame_buffer_props.sv
testbench/tb_frame_buffer.sv

// File: testbench/frame_buffer_props.sv
`timescale 1ns/100ps

module frame_buffer_props import video_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input video_pos_t pos,
  input logic       busy,
  input logic       hold,
  input line_wr_t   line_wr,
  input logic [3:0] rgb
);

  logic [5:0] writes_q;     // buffer writes since hold rose
  logic [5:0] writes_done;
  logic       busy_seen;
  int         failures = 0;

  always_ff @(posedge clk) begin
    if (!rst_n || !hold) begin
      writes_q  <= 6'd0;
      busy_seen <= 1'b0;
    end else begin
      if (line_wr.we)
        writes_q <= writes_q + 6'd1;
      if (busy)
        busy_seen <= 1'b1;  // processor has released the bus
    end
  end

  // includes a write landing on this edge
  assign writes_done = writes_q + {5'd0, line_wr.we};

  hold_kept_until_row_done: assert property (
    @(posedge clk) disable iff (!rst_n) hold && (writes_done < 6'd32) |=> hold
  ) else begin
    $error("hold dropped before all 32 line buffer writes were done");
    failures++;
  end

  write_needs_busy: assert property (
    @(posedge clk) disable iff (!rst_n) line_wr.we |-> busy_seen
  ) else begin
    $error("line buffer written without busy from the processor");
    failures++;
  end

  black_outside_display: assert property (
    @(posedge clk) disable iff (!rst_n) !pos.display_on |=> (rgb == 4'd0)
  ) else begin
    $error("rgb not black one cycle after display_on was low");
    failures++;
  end

endmodule

bind line_fetch frame_buffer_props fetch_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .pos     (pos),
  .busy    (busy),
  .hold    (hold),
  .line_wr (line_wr),
  .rgb     (4'd0)
);

bind pixel_shifter frame_buffer_props pixel_checks (
  .clk     (clk),
  .rst_n   (rst_n),
  .pos     (pos),
  .busy    (1'b0),
  .hold    (1'b0),
  .line_wr ('0),
  .rgb     (rgb)
);

// File: testbench/tb_frame_buffer.sv
`timescale 1ns/100ps

module tb_frame_buffer import video_pkg::*; ();

  localparam int H_TOTAL    = 320;
  localparam int V_TOTAL    = 262;
  localparam int SEED       = 97346;
  localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL;
  localparam int HOLD_LIMIT = 100;    // longest hold is about 50 cycles
  localparam logic [3:0][3:0] COLORS = {4'd7, 4'd4, 4'd1, 4'd0};

  logic        clk;
  logic        rst_n;
  cpu_bus_t    bus;
  logic [15:0] rdata;
  logic        busy;
  logic        hold;
  logic        hpaddle;
  logic        vpaddle;
  logic        hsync;
  logic        vsync;
  logic [3:0]  rgb;

  // reference model state updated 1 ns after each rising edge
  logic [15:0] mem_model [0:32767];
  int          mh = 0;
  int          mv = 0;
  int          frame_count = 0;
  bit          m_hs;
  bit          m_vs;
  bit          m_de;
  bit          mhold = 1'b0;
  bit          busy_seen = 1'b0;
  int          copy_cycles = 0;
  bit          pixels_valid = 1'b0;  // row 0 fetched once after reset
  int          answer_delay = -1;

  frame_buffer_top #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus     (bus),
    .rdata   (rdata),
    .busy    (busy),
    .hold    (hold),
    .hpaddle (hpaddle),
    .vpaddle (vpaddle),
    .hsync   (hsync),
    .vsync   (vsync),
    .rgb     (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
    $display("ERROR at %0d ns: %s expected %h got %h", $time, name, expected, actual);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic report_property_failure();
    $display("a bound assertion on hold, line buffer writes or rgb failed at %0d ns",
             $time);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first property failure");
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout at %0d ns: %s", $time, what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped by timeout");
  endtask

  function automatic int next_row(input int v);
    return (v == V_TOTAL - 1) ? 0 : v + 1;
  endfunction

  function automatic logic [3:0] expected_pixel(input int h, input int v);
    logic [15:0] word;
    logic [1:0]  code;
    word = mem_model[ROW_BASE + v * LINE_WORDS + h / 8];
    code = word[2 * (h % 8) +: 2];
    return COLORS[code];
  endfunction

  function automatic logic [15:0] expected_read(input logic [15:0] addr);
    if (addr[15])
      return 16'd0;
    if (addr[14:8] != 7'h7F)
      return mem_model[addr[14:0]];
    case (addr[7:0])
      8'h00:   return {8'd0, mh[7:0]};
      8'h01:   return {8'd0, mv[7:0]};
      8'h02:   return {11'd0, m_vs, m_hs, vpaddle, hpaddle, m_de};
      default: return 16'd0;
    endcase
  endfunction

  task automatic check_cycle();
    int          ph;
    int          pv;
    bit          rgb_known;
    logic [3:0]  exp_rgb;
    logic [15:0] exp_rd;
    ph = mh;
    pv = mv;
    if (bus.write && !bus.addr[15])
      mem_model[bus.addr[14:0]] = bus.wdata;  // store landed on this edge
    rgb_known = 1'b1;
    exp_rgb   = 4'd0;
    if (rst_n && ph < H_VISIBLE && pv < V_VISIBLE) begin
      rgb_known = pixels_valid;
      exp_rgb   = expected_pixel(ph, pv);
    end
    if (!rst_n) begin
      mhold     = 1'b0;
      busy_seen = 1'b0;
    end else if (mhold) begin
      if (busy_seen) begin
        copy_cycles++;
        if (copy_cycles == LINE_WORDS + 1) begin  // one extra for the read latency
          mhold     = 1'b0;
          busy_seen = 1'b0;
        end
      end else if (busy) begin
        busy_seen   = 1'b1;
        copy_cycles = 0;
      end
    end else if (ph == H_VISIBLE && next_row(pv) < V_VISIBLE) begin
      mhold = 1'b1;
    end
    if (!rst_n) begin
      mh = 0;
      mv = 0;
    end else if (mh == H_TOTAL - 1) begin
      mh = 0;
      if (mv == V_TOTAL - 1) begin
        mv           = 0;
        frame_count++;
        pixels_valid = 1'b1;
      end else begin
        mv++;
      end
    end else begin
      mh++;
    end
    m_de = (mh < H_VISIBLE) && (mv < V_VISIBLE);
    m_hs = (mh >= H_VISIBLE + H_SYNC_OFFSET) &&
           (mh < H_VISIBLE + H_SYNC_OFFSET + H_SYNC_WIDTH);
    m_vs = (mv >= V_VISIBLE + V_SYNC_OFFSET) &&
           (mv < V_VISIBLE + V_SYNC_OFFSET + V_SYNC_WIDTH);
    assert (hsync === m_hs) else report_mismatch("hsync", m_hs, hsync);
    assert (vsync === m_vs) else report_mismatch("vsync", m_vs, vsync);
    assert (hold === mhold) else report_mismatch("hold", mhold, hold);
    if (rgb_known)
      assert (rgb === exp_rgb) else report_mismatch("rgb", exp_rgb, rgb);
    if (!bus.write) begin
      exp_rd = expected_read(bus.addr);
      if (!$isunknown(exp_rd))  // unwritten RAM words are not checked
        assert (rdata === exp_rd) else report_mismatch("rdata", exp_rd, rdata);
    end
    assert (DUT.u_fetch.fetch_checks.failures == 0 &&
            DUT.u_pixel.pixel_checks.failures == 0)
      else report_property_failure();
  endtask

  // processor side of the hold/busy exchange
  task automatic answer_hold();
    if (!hold) begin
      busy         = 1'b0;
      answer_delay = -1;
    end else if (!busy) begin
      if (answer_delay < 0)
        answer_delay = $urandom_range(15, 0);
      if (answer_delay == 0)
        busy = 1'b1;
      else
        answer_delay--;
    end
  endtask

  always @(posedge clk) begin
    #1;
    check_cycle();
    #1;
    answer_hold();
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic wait_bus_free();
    int n;
    n = 0;
    while (hold) begin
      if (n == HOLD_LIMIT)
        fail_timeout("hold did not fall back");
      n++;
      next_cycle();
    end
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [15:0] data);
    wait_bus_free();
    bus.addr  = addr;
    bus.wdata = data;
    bus.write = 1'b1;
    next_cycle();
    bus.write = 1'b0;  // address stays on the bus
  endtask

  task automatic bus_read(input logic [15:0] addr);
    wait_bus_free();
    bus.addr  = addr;
    bus.write = 1'b0;
    next_cycle();
  endtask

  task automatic read_flags_until(input int frame, input int line);
    int n;
    n         = 0;
    bus.addr  = 16'h7F02;
    bus.write = 1'b0;
    while (!(frame_count == frame && mv == line)) begin
      if (n == WAIT_LIMIT)
        fail_timeout($sformatf("frame %0d line %0d never reached", frame, line));
      n++;
      hpaddle = 1'($urandom_range(1, 0));
      vpaddle = 1'($urandom_range(1, 0));
      next_cycle();
    end
  endtask

  task automatic rewrite_rows(input int count);
    repeat (count)
      bus_write(ROW_BASE + 16'($urandom_range(V_VISIBLE * LINE_WORDS - 1, 0)),
                16'($urandom));
  endtask

  initial begin
    logic [15:0] addr;
    logic [15:0] written [$];
    int          sel;
    rst_n   = 1'b0;
    bus     = '0;
    busy    = 1'b0;
    hpaddle = 1'b0;
    vpaddle = 1'b0;
    void'($urandom(SEED));
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;

    for (int a = 0; a < V_VISIBLE * LINE_WORDS; a++)
      bus_write(ROW_BASE + 16'(a), 16'($urandom));

    repeat (64) begin
      addr = 16'($urandom_range(16'h7EFF, 0));
      bus_write(addr, 16'($urandom));
      written.push_back(addr);
    end
    foreach (written[i])
      bus_read(written[i]);
    repeat (16)
      bus_read(16'h8000 | 16'($urandom));

    // I/O page with paddles changing under the reads
    repeat (64) begin
      sel     = $urandom_range(3, 0);
      hpaddle = 1'($urandom_range(1, 0));
      vpaddle = 1'($urandom_range(1, 0));
      if (sel < 3)
        addr = 16'h7F00 | 16'(sel);
      else
        addr = 16'h7F00 | 16'($urandom_range(255, 3));
      bus_read(addr);
    end

    read_flags_until(1, 0);
    read_flags_until(1, V_VISIBLE + 1);
    rewrite_rows(128);
    read_flags_until(2, V_VISIBLE + 1);
    rewrite_rows(128);
    read_flags_until(3, 0);

    if (DUT.u_fetch.fetch_checks.failures == 0 && DUT.u_pixel.pixel_checks.failures == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("bound property checks reported failures");
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: verilog/bus_memory.sv
`timescale 1ns/100ps

module bus_memory import video_pkg::*; (
  input  logic        clk,
  input  cpu_bus_t    bus,
  output logic [15:0] rdata,
  input  video_pos_t  pos,
  input  logic        hpaddle,
  input  logic        vpaddle,
  input  logic [14:0] fetch_addr,
  output logic [15:0] fetch_data
);

  localparam logic [6:0] IO_PAGE = 7'h7F;

  logic [15:0] ram [0:32767];
  logic        io_hit;

  // processor store, upper half of the address space is not writable
  always_ff @(posedge clk) begin
    if (bus.write && !bus.addr[15])
      ram[bus.addr[14:0]] <= bus.wdata;
  end

  // scanline engine port, one cycle latency
  always_ff @(posedge clk) begin
    fetch_data <= ram[fetch_addr];
  end

  assign io_hit = (bus.addr[14:8] == IO_PAGE);

  // processor load is combinational
  always_comb begin
    rdata = 16'd0;
    if (!bus.addr[15]) begin
      if (io_hit) begin
        case (io_reg_e'(bus.addr[7:0]))
          IO_HPOS:  rdata = {8'd0, pos.hpos[7:0]};
          IO_VPOS:  rdata = {8'd0, pos.vpos[7:0]};
          IO_FLAGS: rdata = {11'd0, pos.vsync, pos.hsync, vpaddle, hpaddle,
                             pos.display_on};
          default:  rdata = 16'd0;  // unused registers in the page
        endcase
      end else begin
        rdata = ram[bus.addr[14:0]];
      end
    end
  end

endmodule

// File: verilog/frame_buffer_top.sv
`timescale 1ns/100ps

module frame_buffer_top import video_pkg::*; #(
  parameter int H_TOTAL = 320,
  parameter int V_TOTAL = 262
) (
  input  logic        clk,
  input  logic        rst_n,
  input  cpu_bus_t    bus,
  output logic [15:0] rdata,
  input  logic        busy,
  output logic        hold,
  input  logic        hpaddle,
  input  logic        vpaddle,
  output logic        hsync,
  output logic        vsync,
  output logic [3:0]  rgb
);

  video_pos_t  pos;
  logic [14:0] fetch_addr;
  logic [15:0] fetch_data;
  line_wr_t    line_wr;

  raster_timing #(
    .H_TOTAL (H_TOTAL),
    .V_TOTAL (V_TOTAL)
  ) u_timing (
    .clk   (clk),
    .rst_n (rst_n),
    .pos   (pos)
  );

  bus_memory u_memory (
    .clk        (clk),
    .bus        (bus),
    .rdata      (rdata),
    .pos        (pos),
    .hpaddle    (hpaddle),
    .vpaddle    (vpaddle),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data)
  );

  line_fetch #(
    .V_TOTAL (V_TOTAL)
  ) u_fetch (
    .clk        (clk),
    .rst_n      (rst_n),
    .pos        (pos),
    .busy       (busy),
    .hold       (hold),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .line_wr    (line_wr)
  );

  pixel_shifter u_pixel (
    .clk     (clk),
    .rst_n   (rst_n),
    .pos     (pos),
    .line_wr (line_wr),
    .rgb     (rgb)
  );

  // sync pins come straight from the registered raster position
  assign hsync = pos.hsync;
  assign vsync = pos.vsync;

endmodule

// File: verilog/line_fetch.sv
`timescale 1ns/100ps

module line_fetch import video_pkg::*; #(
  parameter int V_TOTAL = 262
) (
  input  logic        clk,
  input  logic        rst_n,
  input  video_pos_t  pos,
  input  logic        busy,
  output logic        hold,
  output logic [14:0] fetch_addr,
  input  logic [15:0] fetch_data,
  output line_wr_t    line_wr
);

  localparam logic [4:0] LAST_WORD = 5'(LINE_WORDS - 1);

  dma_state_e state;
  logic [8:0] next_row;
  logic [8:0] row_q;     // row being copied
  logic [4:0] rd_idx;
  logic [4:0] wr_idx;
  logic       wr_pend;   // fetch_data holds a word to store
  logic       start;

  // the row shown on the following line, wrapping to the top of the frame
  always_comb begin
    if (pos.vpos == 9'(V_TOTAL - 1))
      next_row = 9'd0;
    else
      next_row = pos.vpos + 9'd1;
  end

  assign start = (state == DMA_IDLE) && (next_row < 9'(V_VISIBLE)) &&
                 (pos.hpos >= 9'(H_VISIBLE)) &&
                 (pos.hpos < 9'(H_VISIBLE + FETCH_WINDOW));

  always_ff @(posedge clk) begin
    if (start)
      row_q <= next_row;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= DMA_IDLE;
      hold    <= 1'b0;
      rd_idx  <= 5'd0;
      wr_idx  <= 5'd0;
      wr_pend <= 1'b0;
    end else begin
      wr_pend <= (state == DMA_COPY);  // read issued this cycle
      wr_idx  <= rd_idx;
      case (state)
        DMA_IDLE: begin
          if (start) begin
            state <= DMA_WAIT_BUSY;
            hold  <= 1'b1;
          end
        end
        DMA_WAIT_BUSY: begin
          if (busy) begin  // bus released by the processor
            state  <= DMA_COPY;
            rd_idx <= 5'd0;
          end
        end
        DMA_COPY: begin
          rd_idx <= rd_idx + 5'd1;
          if (rd_idx == LAST_WORD)
            state <= DMA_IDLE;
        end
        default: state <= DMA_IDLE;
      endcase
      // give the bus back with the last buffer write
      if (wr_pend && wr_idx == LAST_WORD)
        hold <= 1'b0;
    end
  end

  assign fetch_addr = ROW_BASE[14:0] + {1'b0, row_q, rd_idx};

  assign line_wr.we    = wr_pend;
  assign line_wr.index = wr_idx;
  assign line_wr.data  = fetch_data;

endmodule

// File: verilog/pixel_shifter.sv
`timescale 1ns/100ps

module pixel_shifter import video_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  video_pos_t pos,
  input  line_wr_t   line_wr,
  output logic [3:0] rgb
);

  logic [15:0] line_buf [0:LINE_WORDS-1];  // 32 words, 256 pixels of 2 bits
  logic [15:0] shift_q;
  logic [15:0] word;
  logic [1:0]  pix;
  logic        word_start;

  // filled by the fetch engine during horizontal blanking
  always_ff @(posedge clk) begin
    if (line_wr.we)
      line_buf[line_wr.index] <= line_wr.data;
  end

  assign word_start = (pos.hpos[2:0] == 3'd0);

  always_comb begin
    word = line_buf[pos.hpos[7:3]];
    // first pixel comes straight from the buffer, the rest from the shifter
    if (word_start)
      pix = word[1:0];
    else
      pix = shift_q[1:0];
  end

  always_ff @(posedge clk) begin
    if (word_start)
      shift_q <= word >> 2;
    else
      shift_q <= shift_q >> 2;
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      rgb <= 4'd0;
    else if (pos.display_on)
      rgb <= PALETTE[pix];
    else
      rgb <= 4'd0;  // black outside the visible area
  end

endmodule

// File: verilog/raster_timing.sv
`timescale 1ns/100ps

module raster_timing import video_pkg::*; #(
  parameter int H_TOTAL = 320,
  parameter int V_TOTAL = 262
) (
  input  logic       clk,
  input  logic       rst_n,
  output video_pos_t pos
);

  localparam int H_SYNC_START = H_VISIBLE + H_SYNC_OFFSET;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC_WIDTH;
  localparam int V_SYNC_START = V_VISIBLE + V_SYNC_OFFSET;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC_WIDTH;

  logic [8:0] h_next;
  logic [8:0] v_next;

  // all levels are decoded from the same counter values they travel with
  function automatic video_pos_t decode(input logic [8:0] h, input logic [8:0] v);
    video_pos_t p;
    p.hpos       = h;
    p.vpos       = v;
    p.display_on = (h < 9'(H_VISIBLE)) && (v < 9'(V_VISIBLE));
    p.hsync      = (h >= 9'(H_SYNC_START)) && (h < 9'(H_SYNC_END));
    p.vsync      = (v >= 9'(V_SYNC_START)) && (v < 9'(V_SYNC_END));
    return p;
  endfunction

  always_comb begin
    h_next = pos.hpos + 9'd1;
    v_next = pos.vpos;
    if (pos.hpos == 9'(H_TOTAL - 1)) begin
      h_next = 9'd0;
      // line wrap moves the vertical counter
      if (pos.vpos == 9'(V_TOTAL - 1))
        v_next = 9'd0;
      else
        v_next = pos.vpos + 9'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      pos <= decode(9'd0, 9'd0);  // top left corner, display already on
    else
      pos <= decode(h_next, v_next);
  end

endmodule

// File: verilog/video_pkg.sv
package video_pkg;

  // processor request as seen by the frame buffer
  typedef struct packed {
    logic [15:0] addr;
    logic [15:0] wdata;
    logic        write;   // store strobe, sampled at the rising edge
  } cpu_bus_t;

  // registered raster position and its decoded levels
  typedef struct packed {
    logic [8:0] hpos;
    logic [8:0] vpos;
    logic       display_on;
    logic       hsync;
    logic       vsync;
  } video_pos_t;

  // one word into the scanline buffer
  typedef struct packed {
    logic        we;
    logic [4:0]  index;
    logic [15:0] data;
  } line_wr_t;

  typedef enum logic [1:0] {
    DMA_IDLE      = 2'd0,
    DMA_WAIT_BUSY = 2'd1,
    DMA_COPY      = 2'd2
  } dma_state_e;

  // low byte of the address inside page 0x7F
  typedef enum logic [7:0] {
    IO_HPOS  = 8'h00,
    IO_VPOS  = 8'h01,
    IO_FLAGS = 8'h02
  } io_reg_e;

  localparam int H_VISIBLE     = 256;
  localparam int V_VISIBLE     = 240;
  localparam int LINE_WORDS    = 32;
  localparam int FETCH_WINDOW  = 4;   // hpos 256..259 may open the hold
  localparam logic [15:0] ROW_BASE = 16'h4000;
  localparam int H_SYNC_OFFSET = 16;
  localparam int H_SYNC_WIDTH  = 24;
  localparam int V_SYNC_OFFSET = 4;
  localparam int V_SYNC_WIDTH  = 3;

  // four 2-bit pixel codes to 4-bit colors, entry 0 is index 0
  localparam logic [3:0][3:0] PALETTE = {4'd7, 4'd4, 4'd1, 4'd0};

endpackage
